// ==== project.f ====
+incdir+include
rtl/dtim_pkg.sv
rtl/dtim_ram.sv
rtl/dtim_ctrl.sv
rtl/dmem_store.sv
rtl/dtim_top.sv
tests/dtim_tb.sv

// ==== Makefile ====
TOP = dtim_tb

all: run

build:
	verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module $(TOP) \
		-f project.f -o $(TOP)

run: build
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	grep -q "Done: no errors" sim.log

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps --top-module $(TOP) \
		-f project.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// ==== tests/dtim_input.txt ====
# name kind addr strobe wdata expected latency
# Columns hold hex values except latency, which counts cycles to ready and is 0 for a fence
rd_cold_miss     read  00001010 0 00000000 00000000 4
rd_cold_hit      read  00001010 0 00000000 00000000 1
wr_hit_low       write 00001010 3 deadbeef 00000000 1
wr_hit_high      write 00001010 8 12345678 00000000 1
rd_hit_merged    read  00001010 0 00000000 1200beef 1
wr_miss_part     write 00001024 4 aabbccdd 00000000 4
rd_miss_alloc    read  00001024 0 00000000 00bb0000 1
wr_outside       write 00000080 f cafef00d 00000000 4
rd_outside       read  00000080 0 00000000 cafef00d 4
wr_conflict      write 00001110 f 55aa33cc 00000000 4
rd_conflict      read  00001110 0 00000000 55aa33cc 4
wr_miss_full     write 00001034 f 0badf00d 00000000 4
fence_dirty      fence 00000000 0 00000000 00000000 0
rd_wb_merged     read  00001010 0 00000000 1200beef 4
rd_wb_part       read  00001024 0 00000000 00bb0000 4
rd_wb_full       read  00001034 0 00000000 0badf00d 4
rd_conflict_keep read  00001110 0 00000000 55aa33cc 4
fence_clean      fence 00000000 0 00000000 00000000 0
wr_miss_backing  write 00001110 1 111111ee 00000000 4
rd_miss_backing  read  00001110 0 00000000 55aa33ee 1
rd_after_clean   read  00001024 0 00000000 00bb0000 4

// ==== tests/dtim_tb.sv ====
`include "dtim_params.svh"

module dtim_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import dtim_pkg::*;

  typedef enum logic [1:0] {op_read, op_write, op_fence} op_kind_e;

  logic clock = 1'b0;
  logic reset;
  mem_req_t cpu_req;
  mem_rsp_t cpu_rsp;

  // Operation list loaded from the input file
  string op_name [$];
  op_kind_e op_kind [$];
  logic [31:0] op_addr [$];
  logic [3:0] op_strb [$];
  logic [31:0] op_wdata [$];
  logic [31:0] op_expected [$];
  int op_latency [$];

  int cycle_count = 0;
  int cycle_limit = 0;              // Zero until the file is read

  dtim_top uut (
    .clock (clock),
    .reset (reset),
    .cpu_req (cpu_req),
    .cpu_rsp (cpu_rsp)
  );

  always #20 clock = ~clock;

  task automatic stop_on_error(input string reason);
    $display("%s", reason);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped at first error");
  endtask

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      stop_on_error("Timeout: no ready from DUT");
    end
  end

  task automatic check_rsp(input string name, input mem_rsp_t expected, input mem_rsp_t actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("Mismatch in %s: expected %h, actual %h",
                              name, expected.rdata, actual.rdata));
    end
  endtask

  task automatic check_latency(input string name, input int expected, input int actual);
    if (actual != expected) begin
      stop_on_error($sformatf("Mismatch in %s latency: expected %0d cycles, actual %0d cycles",
                              name, expected, actual));
    end
  endtask

  task automatic read_op_file();
    int fd;
    int fields;
    logic [8*128-1:0] line_buf;
    logic [8*32-1:0] name_buf;
    logic [8*8-1:0] kind_buf;
    logic [31:0] addr;
    logic [3:0] strb;
    logic [31:0] wdata;
    logic [31:0] expected_data;
    int latency;
    fd = $fopen("tests/dtim_input.txt", "r");
    if (fd == 0) begin
      stop_on_error("Cannot open tests/dtim_input.txt");
    end
    while (!$feof(fd)) begin
      line_buf = '0;
      name_buf = '0;
      kind_buf = '0;
      if ($fgets(line_buf, fd) != 0) begin
        fields = $sscanf(line_buf, "%s %s %h %h %h %h %d", name_buf, kind_buf, addr, strb,
                         wdata, expected_data, latency);
        if (fields == 7) begin    // Comment and blank lines fall through
          if (kind_buf == 64'("read")) begin
            op_kind.push_back(op_read);
          end else if (kind_buf == 64'("write")) begin
            op_kind.push_back(op_write);
          end else if (kind_buf == 64'("fence")) begin
            op_kind.push_back(op_fence);
          end else begin
            stop_on_error($sformatf("Unknown operation kind %s in tests/dtim_input.txt",
                                    string'(kind_buf)));
          end
          // A read carries no strobe and a write at least one byte
          if ((op_kind[$] == op_read && strb != 4'h0) ||
              (op_kind[$] == op_write && strb == 4'h0)) begin
            stop_on_error($sformatf("Strobe %h does not fit operation %s in tests/dtim_input.txt",
                                    strb, string'(name_buf)));
          end
          op_name.push_back(string'(name_buf));
          op_addr.push_back(addr);
          op_strb.push_back(strb);
          op_wdata.push_back(wdata);
          op_expected.push_back(expected_data);
          op_latency.push_back(latency);
        end
      end
    end
    $fclose(fd);
  endtask

  // One request pulse, then wait for ready sampled mid-cycle
  task automatic run_op(input int i);
    mem_rsp_t rsp;
    mem_rsp_t expected_rsp;
    int latency;
    @(negedge clock);
    if (cpu_rsp.ready) begin
      stop_on_error($sformatf("Ready was high while idle before %s", op_name[i]));
    end
    cpu_req.valid = 1'b1;
    cpu_req.fence = (op_kind[i] == op_fence);
    cpu_req.addr = op_addr[i];
    cpu_req.wdata = op_wdata[i];
    cpu_req.strb = op_strb[i];
    latency = 0;
    rsp = '0;
    while (!rsp.ready) begin
      @(negedge clock);
      rsp = cpu_rsp;
      cpu_req = '0;
      latency++;
    end
    expected_rsp.ready = 1'b1;
    expected_rsp.rdata = op_expected[i];
    check_rsp(op_name[i], expected_rsp, rsp);
    if (op_latency[i] != 0) begin
      check_latency(op_name[i], op_latency[i], latency);
    end
  endtask

  initial begin
    int per_op;
    int fence_count;
    reset = 1'b0;
    cpu_req = '0;
    read_op_file();
    if (op_name.size() == 0) begin
      stop_on_error("No operations found in tests/dtim_input.txt");
    end
    per_op = 1 + `DMEM_LATENCY;
    fence_count = 0;
    foreach (op_kind[i]) begin
      if (op_kind[i] == op_fence) begin
        fence_count++;
      end
    end
    // Reset cycles, worst-case latency per operation and a full walk per fence, doubled
    cycle_limit = 10 + 2 * (per_op * op_name.size()
                  + fence_count * `DTIM_DEPTH * `DTIM_WIDTH * per_op) + 20;
    repeat (10) @(negedge clock);
    reset = 1'b1;
    foreach (op_name[i]) begin
      run_op(i);
    end
    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== rtl/dtim_top.sv ====
`include "dtim_params.svh"

module dtim_top (
  input logic clock,
  input logic reset,
  input dtim_pkg::mem_req_t cpu_req,
  output dtim_pkg::mem_rsp_t cpu_rsp
);

  import dtim_pkg::*;

  ram_in_t ram_in [`DTIM_WIDTH];
  ram_out_t ram_out [`DTIM_WIDTH];

  mem_req_t dmem_req;
  mem_rsp_t dmem_rsp;

  dtim_ctrl u_ctrl (
    .clock (clock),
    .reset (reset),
    .cpu_req (cpu_req),
    .cpu_rsp (cpu_rsp),
    .ram_in (ram_in),
    .ram_out (ram_out),
    .dmem_req (dmem_req),
    .dmem_rsp (dmem_rsp)
  );

  // One RAM per word column
  for (genvar c = 0; c < `DTIM_WIDTH; c++) begin : g_column
    dtim_ram u_ram (
      .clock (clock),
      .ram_in (ram_in[c]),
      .ram_out (ram_out[c])
    );
  end

  dmem_store u_store (
    .clock (clock),
    .reset (reset),
    .dmem_req (dmem_req),
    .dmem_rsp (dmem_rsp)
  );

endmodule

// ==== rtl/dmem_store.sv ====
`include "dtim_params.svh"

module dmem_store (
  input logic clock,
  input logic reset,
  input dtim_pkg::mem_req_t dmem_req,
  output dtim_pkg::mem_rsp_t dmem_rsp
);

  import dtim_pkg::*;

  localparam int addr_bits = $clog2(`DMEM_WORDS);
  localparam int count_bits = $clog2(`DMEM_LATENCY + 1);

  logic [31:0] mem_array [`DMEM_WORDS] = '{default: '0};

  mem_req_t req_q;
  logic busy;
  logic done;
  logic [count_bits-1:0] count;
  logic [addr_bits-1:0] word_addr;

  assign word_addr = req_q.addr[addr_bits+1:2];
  assign done = busy && (count == '0);

  always_ff @(posedge clock) begin
    if (!reset) begin
      busy <= 1'b0;
      count <= '0;
    end else if (busy) begin
      if (count == '0) begin
        busy <= 1'b0;
      end else begin
        count <= count - 1'b1;
      end
    end else if (dmem_req.valid) begin
      busy <= 1'b1;
      count <= count_bits'(`DMEM_LATENCY - 1);
    end
  end

  always_ff @(posedge clock) begin
    if (!busy && dmem_req.valid) begin
      req_q <= dmem_req;
    end
    if (done) begin
      for (int b = 0; b < 4; b++) begin
        if (req_q.strb[b]) begin
          mem_array[word_addr][8*b +: 8] <= req_q.wdata[8*b +: 8];
        end
      end
    end
  end

  assign dmem_rsp.ready = done;
  assign dmem_rsp.rdata = (done && req_q.strb == 4'h0) ? mem_array[word_addr] : 32'h0;

endmodule

// ==== rtl/dtim_ctrl.sv ====
`include "dtim_params.svh"

module dtim_ctrl (
  input logic clock,
  input logic reset,
  input dtim_pkg::mem_req_t cpu_req,
  output dtim_pkg::mem_rsp_t cpu_rsp,
  output dtim_pkg::ram_in_t ram_in [`DTIM_WIDTH],
  input dtim_pkg::ram_out_t ram_out [`DTIM_WIDTH],
  output dtim_pkg::mem_req_t dmem_req,
  input dtim_pkg::mem_rsp_t dmem_rsp
);

  import dtim_pkg::*;

  mem_req_t req_q;
  logic pending;

  ctrl_state_e state;
  ctrl_state_e state_next;
  logic [index_bits-1:0] fence_index;
  logic [index_bits-1:0] fence_index_next;
  logic [column_bits-1:0] fence_column;
  logic [column_bits-1:0] fence_column_next;
  logic wb_wait;
  logic wb_wait_next;
  logic fence_step;

  logic [tag_bits-1:0] req_tag;
  logic [index_bits-1:0] req_index;
  logic [column_bits-1:0] req_column;
  logic [index_bits-1:0] cpu_index;
  logic [column_bits-1:0] cpu_column;
  logic in_window;
  logic req_write;

  entry_t lookup_entry;
  entry_t fence_entry;
  logic [31:0] hit_data;
  logic [31:0] fill_data;

  logic wen;
  logic [column_bits-1:0] wcolumn;
  logic [index_bits-1:0] waddr;
  entry_t wentry;

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0] strb);
    logic [31:0] merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

  // Front stage
  always_ff @(posedge clock) begin
    if (!reset) begin
      pending <= 1'b0;
    end else begin
      pending <= cpu_req.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (cpu_req.valid) begin
      req_q <= cpu_req;
    end
  end

  assign cpu_index = cpu_req.addr[column_bits+2 +: index_bits];
  assign cpu_column = cpu_req.addr[2 +: column_bits];

  assign req_tag = req_q.addr[31 -: tag_bits];
  assign req_index = req_q.addr[column_bits+2 +: index_bits];
  assign req_column = req_q.addr[2 +: column_bits];
  assign req_write = |req_q.strb;
  assign in_window = (req_q.addr >= `DTIM_BASE_ADDR) && (req_q.addr < `DTIM_TOP_ADDR);

  assign lookup_entry = ram_out[req_column].rentry;
  assign fence_entry = ram_out[fence_column].rentry;
  assign hit_data = merge_bytes(lookup_entry.data, req_q.wdata, req_q.strb);
  assign fill_data = merge_bytes(dmem_rsp.rdata, req_q.wdata, req_q.strb);

  // Back stage
  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= state_lookup;
      fence_index <= '0;
      fence_column <= '0;
      wb_wait <= 1'b0;
    end else begin
      state <= state_next;
      fence_index <= fence_index_next;
      fence_column <= fence_column_next;
      wb_wait <= wb_wait_next;
    end
  end

  always_comb begin
    state_next = state;
    fence_index_next = fence_index;
    fence_column_next = fence_column;
    wb_wait_next = wb_wait;
    fence_step = 1'b0;
    cpu_rsp = '0;
    dmem_req = '0;
    wen = 1'b0;
    wcolumn = req_column;
    waddr = req_index;
    wentry = '0;

    case (state)
      state_lookup: begin
        if (pending) begin
          if (req_q.fence) begin
            state_next = state_fence;
            fence_index_next = '0;
            fence_column_next = '0;
            wb_wait_next = 1'b0;
          end else if (!in_window || (lookup_entry.lock && lookup_entry.tag != req_tag)) begin
            state_next = state_bypass;
            dmem_req.valid = 1'b1;
            dmem_req.addr = req_q.addr;
            dmem_req.wdata = req_q.wdata;
            dmem_req.strb = req_q.strb;
          end else if (!lookup_entry.lock) begin
            state_next = state_miss;
            dmem_req.valid = 1'b1;
            dmem_req.addr = {req_q.addr[31:2], 2'b00}; // Fetch whole word, merge later
          end else begin
            cpu_rsp.ready = 1'b1;
            cpu_rsp.rdata = req_write ? 32'h0 : lookup_entry.data;
            wen = req_write;
            wentry = '{lock: 1'b1, dirty: 1'b1, tag: req_tag, data: hit_data};
          end
        end
      end

      state_miss: begin
        if (dmem_rsp.ready) begin
          state_next = state_lookup;
          cpu_rsp.ready = 1'b1;
          cpu_rsp.rdata = req_write ? 32'h0 : dmem_rsp.rdata;
          wen = 1'b1;
          wentry = '{lock: 1'b1, dirty: req_write, tag: req_tag, data: fill_data};
        end
      end

      state_bypass: begin
        if (dmem_rsp.ready) begin
          state_next = state_lookup;
          cpu_rsp.ready = 1'b1;
          cpu_rsp.rdata = dmem_rsp.rdata;
        end
      end

      state_fence: begin
        wcolumn = fence_column;
        waddr = fence_index;
        if (wb_wait) begin
          fence_step = dmem_rsp.ready;
        end else begin
          wen = 1'b1; // Clear the entry on its first visit
          if (fence_entry.lock && fence_entry.dirty) begin
            wb_wait_next = 1'b1;
            dmem_req.valid = 1'b1;
            dmem_req.addr = {fence_entry.tag, fence_index, fence_column, 2'b00};
            dmem_req.wdata = fence_entry.data;
            dmem_req.strb = 4'hf;
          end else begin
            fence_step = 1'b1;
          end
        end
        if (fence_step) begin
          wb_wait_next = 1'b0;
          if (&fence_column) begin
            fence_column_next = '0;
            if (&fence_index) begin
              state_next = state_lookup;
              cpu_rsp.ready = 1'b1;
            end else begin
              fence_index_next = fence_index + 1'b1;
            end
          end else begin
            fence_column_next = fence_column + 1'b1;
          end
        end
      end

      default: begin
        state_next = state_lookup;
      end
    endcase
  end

  // RAM column ports
  always_comb begin
    for (int c = 0; c < `DTIM_WIDTH; c++) begin
      ram_in[c].wen = wen && (wcolumn == column_bits'(c));
      ram_in[c].waddr = waddr;
      ram_in[c].wentry = wentry;
      if (state_next == state_fence) begin
        ram_in[c].raddr = fence_index_next; // Whole row is read during fence
      end else if (cpu_column == column_bits'(c)) begin
        ram_in[c].raddr = cpu_index;
      end else begin
        ram_in[c].raddr = '0;
      end
    end
  end

endmodule

// ==== rtl/dtim_ram.sv ====
`include "dtim_params.svh"

module dtim_ram (
  input logic clock,
  input dtim_pkg::ram_in_t ram_in,
  output dtim_pkg::ram_out_t ram_out
);

  import dtim_pkg::*;

  // All entries start unlocked
  entry_t ram_array [`DTIM_DEPTH] = '{default: '0};

  logic [index_bits-1:0] raddr = '0;

  always_ff @(posedge clock) begin
    raddr <= ram_in.raddr;
    if (ram_in.wen) begin
      ram_array[ram_in.waddr] <= ram_in.wentry;
    end
  end

  assign ram_out.rentry = ram_array[raddr]; // Read through registered index

endmodule

// ==== rtl/dtim_pkg.sv ====
`include "dtim_params.svh"

package dtim_pkg;

  localparam int index_bits = $clog2(`DTIM_DEPTH);
  localparam int column_bits = $clog2(`DTIM_WIDTH);
  localparam int tag_bits = 32 - index_bits - column_bits - 2;

  typedef struct packed {
    logic valid;
    logic fence;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0] strb;        // Zero means read
  } mem_req_t;

  typedef struct packed {
    logic ready;
    logic [31:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic lock;
    logic dirty;
    logic [tag_bits-1:0] tag;
    logic [31:0] data;
  } entry_t;

  typedef struct packed {
    logic wen;
    logic [index_bits-1:0] waddr;
    logic [index_bits-1:0] raddr;
    entry_t wentry;
  } ram_in_t;

  typedef struct packed {
    entry_t rentry;
  } ram_out_t;

  typedef enum logic [1:0] {state_lookup, state_miss, state_bypass, state_fence} ctrl_state_e;

endpackage

// ==== include/dtim_params.svh ====
`ifndef DTIM_PARAMS_SVH
`define DTIM_PARAMS_SVH

`define DTIM_DEPTH 16                // Entries per column
`define DTIM_WIDTH 4                 // Columns sharing one index

`define DTIM_BASE_ADDR 32'h0000_1000 // Inclusive
`define DTIM_TOP_ADDR 32'h0000_2000  // Exclusive

`define DMEM_WORDS 4096
`define DMEM_LATENCY 3               // Cycles from valid to ready

`endif
